//--- hdl/arcade_io_pkg.sv
// Shared constants and types for the arcade cabinet I/O glue.
// Holds key and joystick bit positions, the keyboard scancodes that drive
// the buttons, the player control word and the default parameter widths.
// Modules take what they need by a wildcard import in their header.
package arcade_io_pkg;

	// ============================================================
	// Held key vector bit positions
	// ============================================================
	localparam int KEY_UP     = 0;
	localparam int KEY_DOWN   = 1;
	localparam int KEY_LEFT   = 2;
	localparam int KEY_RIGHT  = 3;
	localparam int KEY_COIN   = 4;
	localparam int KEY_START1 = 5;
	localparam int KEY_START2 = 6;
	localparam int KEY_FIRE   = 7;

	// ============================================================
	// Keyboard scancodes, set 2 make codes
	// ============================================================
	// Cursor keys
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	// ESC inserts a coin
	localparam logic [7:0] SC_COIN   = 8'h76;
	// F1 and F2
	localparam logic [7:0] SC_START1 = 8'h05;
	localparam logic [7:0] SC_START2 = 8'h06;
	// Space bar
	localparam logic [7:0] SC_FIRE   = 8'h29;

	// ============================================================
	// Joystick word bit positions
	// ============================================================
	// Upper bits carry extra buttons, unused by this cabinet
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// ============================================================
	// Player control word, as the game core expects it
	// ============================================================
	// Field order matches the core's CSJUDLR input
	typedef union packed {
		logic [6:0] raw;
		struct packed {
			logic coin;
			logic start;
			logic fire;
			logic up;
			logic down;
			logic left;
			logic right;
		} fields;
	} ctrl_word_u;

	// Core outputs 3-bit colour, mix of two 8-bit channels needs 11 bits
	localparam int DEF_COLOR_BITS = 3;
	localparam int DEF_AUDIO_BITS = 11;

endpackage

//--- hdl/key_latch.sv
// Keyboard scancode decoder for the cabinet buttons.
// Each key event arrives as a one-cycle strobe with a scancode and a
// pressed flag. Known scancodes load the flag into their held button bit,
// so key_state follows the key one cycle after the strobe. Unknown
// scancodes are ignored.
module key_latch
	import arcade_io_pkg::*;
(
	input  logic       clk_24,
	input  logic       rst_n,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic [7:0] key_code,
	output logic [7:0] key_state
);

	// ============================================================
	// Held button levels
	// ============================================================
	// One bit per cabinet button, cleared by reset
	// A press sets the bit, a release clears it
	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			key_state <= '0;
		end else if (key_strobe) begin
			case (key_code)
				// Directions
				SC_UP: begin
					key_state[KEY_UP] <= key_pressed;
				end
				SC_DOWN: begin
					key_state[KEY_DOWN] <= key_pressed;
				end
				SC_LEFT: begin
					key_state[KEY_LEFT] <= key_pressed;
				end
				SC_RIGHT: begin
					key_state[KEY_RIGHT] <= key_pressed;
				end
				// Coin and start buttons
				SC_COIN: begin
					key_state[KEY_COIN] <= key_pressed;
				end
				SC_START1: begin
					key_state[KEY_START1] <= key_pressed;
				end
				SC_START2: begin
					key_state[KEY_START2] <= key_pressed;
				end
				// Fire
				SC_FIRE: begin
					key_state[KEY_FIRE] <= key_pressed;
				end
				// Any other key, hold state
				default: begin
					key_state <= key_state;
				end
			endcase
		end
	end

	// ============================================================
	// Checks
	// ============================================================
	// Scancode must be fully driven whenever the keyboard side strobes
	a_code_known: assert property (
		@(posedge clk_24) disable iff (!rst_n)
		key_strobe |-> !$isunknown(key_code)
	) else $error("key_code unknown during key_strobe");

endmodule

//--- hdl/control_mapper.sv
// Player control mapper.
// Merges the held keyboard buttons with both joysticks into the two
// player control words of the game core. With rotate set, directions
// turn by a quarter so that controls match a rotated monitor.
// Both words are registered, one cycle behind their inputs.
module control_mapper
	import arcade_io_pkg::*;
(
	input  logic       clk_24,
	input  logic       rst_n,
	input  logic [7:0] key_state,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  logic       rotate,
	output logic [6:0] p1_ctrl,
	output logic [6:0] p2_ctrl
);

	// Direction sources before rotation, key OR either joystick
	logic src_up;
	logic src_down;
	logic src_left;
	logic src_right;
	logic src_fire;

	// Next control words, built field by field
	ctrl_word_u p1_next;
	ctrl_word_u p2_next;

	assign src_up    = key_state[KEY_UP] | joystick_0[JOY_UP] | joystick_1[JOY_UP];
	assign src_down  = key_state[KEY_DOWN] | joystick_0[JOY_DOWN] | joystick_1[JOY_DOWN];
	assign src_left  = key_state[KEY_LEFT] | joystick_0[JOY_LEFT] | joystick_1[JOY_LEFT];
	assign src_right = key_state[KEY_RIGHT] | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];
	assign src_fire  = key_state[KEY_FIRE] | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE];

	// ============================================================
	// Word assembly
	// ============================================================
	always_comb begin
		// Rotated screen: left drives up, up drives right, and so on
		p1_next.fields.up    = rotate ? src_left  : src_up;
		p1_next.fields.down  = rotate ? src_right : src_down;
		p1_next.fields.left  = rotate ? src_down  : src_left;
		p1_next.fields.right = rotate ? src_up    : src_right;
		p1_next.fields.fire  = src_fire;
		p1_next.fields.coin  = key_state[KEY_COIN];
		p1_next.fields.start = key_state[KEY_START1];

		// Player 2 shares stick and fire
		p2_next              = p1_next;
		// Single coin slot, wired to player 1 only
		p2_next.fields.coin  = 1'b0;
		p2_next.fields.start = key_state[KEY_START2];
	end

	// ============================================================
	// Output registers
	// ============================================================
	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			p1_ctrl <= '0;
			p2_ctrl <= '0;
		end else begin
			p1_ctrl <= p1_next.raw;
			p2_ctrl <= p2_next.raw;
		end
	end

endmodule

//--- hdl/sound_mixer.sv
// Two-channel sound mixer.
// Channel b is weighted by four against channel a, as on the original
// board, and the sum is registered as one unsigned sample for the DAC.
module sound_mixer
	import arcade_io_pkg::*;
#(
	parameter int AUDIO_BITS = DEF_AUDIO_BITS
) (
	input  logic                  clk_24,
	input  logic                  rst_n,
	input  logic [7:0]            audio_a,
	input  logic [7:0]            audio_b,
	output logic [AUDIO_BITS-1:0] mix_sample
);

	// Full sum of 255 + 4*255 needs 11 bits
	localparam int SUM_BITS = (AUDIO_BITS > 11) ? AUDIO_BITS : 11;

	logic [SUM_BITS-1:0] sum_full;

	// b shifted up two places, a added at unit weight
	assign sum_full = SUM_BITS'(audio_a) + (SUM_BITS'(audio_b) << 2);

	// ============================================================
	// Sample register
	// ============================================================
	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			mix_sample <= '0;
		end else begin
			mix_sample <= sum_full[AUDIO_BITS-1:0];
		end
	end

	// Narrow AUDIO_BITS would clip the loud channel
	a_sum_in_range: assert property (
		@(posedge clk_24) disable iff (!rst_n)
		(sum_full >> AUDIO_BITS) == '0
	) else $error("mixed sum exceeds sample range");

endmodule

//--- hdl/sigma_delta_dac.sv
// First-order sigma-delta audio DAC.
// An accumulator as wide as the sample adds the sample each cycle; the
// registered carry out is the one-bit pulse stream. Its density is the
// sample over 2**AUDIO_BITS, so an external RC filter recovers the level.
// For a constant sample S, any 2**AUDIO_BITS cycles hold exactly S pulses.
module sigma_delta_dac
	import arcade_io_pkg::*;
#(
	parameter int AUDIO_BITS = DEF_AUDIO_BITS
) (
	input  logic                  clk_24,
	input  logic                  rst_n,
	input  logic [AUDIO_BITS-1:0] mix_sample,
	output logic                  audio_l
);

	// Running error term
	logic [AUDIO_BITS-1:0] acc;
	// Accumulator plus sample, top bit is the carry
	logic [AUDIO_BITS:0]   acc_sum;

	assign acc_sum = {1'b0, acc} + {1'b0, mix_sample};

	// ============================================================
	// Modulator
	// ============================================================
	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			audio_l <= 1'b0;
		end else begin
			// Residue wraps, overflow becomes a pulse
			acc     <= acc_sum[AUDIO_BITS-1:0];
			audio_l <= acc_sum[AUDIO_BITS];
		end
	end

endmodule

//--- hdl/video_blanker.sv
// Video output stage for the VGA DAC.
// Colour is forced to black during horizontal or vertical blanking and
// otherwise widened to 6 bits by repeating its bits from the top, so full
// scale stays full scale. Syncs from the core are active high and leave
// inverted. Every output is registered, one cycle behind the inputs.
module video_blanker
	import arcade_io_pkg::*;
#(
	parameter int COLOR_BITS = DEF_COLOR_BITS
) (
	input  logic                  clk_24,
	input  logic                  rst_n,
	input  logic [COLOR_BITS-1:0] r,
	input  logic [COLOR_BITS-1:0] g,
	input  logic [COLOR_BITS-1:0] b,
	input  logic                  hs,
	input  logic                  vs,
	input  logic                  hb,
	input  logic                  vb,
	output logic [5:0]            vga_r,
	output logic [5:0]            vga_g,
	output logic [5:0]            vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs
);

	// Bit repeat from MSB, 3 bits abc become abcabc
	function automatic logic [5:0] widen(input logic [COLOR_BITS-1:0] c);
		logic [5:0] w;
		for (int i = 0; i < 6; i++) begin
			w[5 - i] = c[COLOR_BITS - 1 - (i % COLOR_BITS)];
		end
		return w;
	endfunction

	logic blank;

	assign blank = hb | vb;

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			// Syncs idle high
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r  <= blank ? 6'd0 : widen(r);
			vga_g  <= blank ? 6'd0 : widen(g);
			vga_b  <= blank ? 6'd0 : widen(b);
			vga_hs <= ~hs;
			vga_vs <= ~vs;
		end
	end

	// Widening only covers 1 to 6 input bits
	a_color_bits: assert property (
		@(posedge clk_24) (COLOR_BITS >= 1) && (COLOR_BITS <= 6)
	) else $error("COLOR_BITS out of range");

endmodule

//--- hdl/arcade_io.sv
// Board-side I/O glue between the game core and the cabinet.
// Three independent lanes: keyboard and joysticks to player control
// words, core RGB and syncs to the VGA DAC, and the two sound channels to
// a one-bit audio stream. Both audio pins carry the same mono stream.
// COLOR_BITS and AUDIO_BITS are set here and handed to the stages.
module arcade_io
	import arcade_io_pkg::*;
#(
	parameter int COLOR_BITS = DEF_COLOR_BITS,
	parameter int AUDIO_BITS = DEF_AUDIO_BITS
) (
	input  logic                  clk_24,
	input  logic                  rst_n,
	// Keyboard events
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  logic [7:0]            key_code,
	// Joysticks and screen orientation
	input  logic [7:0]            joystick_0,
	input  logic [7:0]            joystick_1,
	input  logic                  rotate,
	// Core video
	input  logic [COLOR_BITS-1:0] r,
	input  logic [COLOR_BITS-1:0] g,
	input  logic [COLOR_BITS-1:0] b,
	input  logic                  hs,
	input  logic                  vs,
	input  logic                  hb,
	input  logic                  vb,
	// Core sound
	input  logic [7:0]            audio_a,
	input  logic [7:0]            audio_b,
	// To the core
	output logic [6:0]            p1_ctrl,
	output logic [6:0]            p2_ctrl,
	// To the board
	output logic [5:0]            vga_r,
	output logic [5:0]            vga_g,
	output logic [5:0]            vga_b,
	output logic                  vga_hs,
	output logic                  vga_vs,
	output logic                  audio_l,
	output logic                  audio_r
);

	logic [7:0]            key_state;
	logic [AUDIO_BITS-1:0] mix_sample;

	// ============================================================
	// Control lane
	// ============================================================
	key_latch i_key_latch (
		.clk_24      (clk_24),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.key_state   (key_state)
	);

	control_mapper i_control_mapper (
		.clk_24     (clk_24),
		.rst_n      (rst_n),
		.key_state  (key_state),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (rotate),
		.p1_ctrl    (p1_ctrl),
		.p2_ctrl    (p2_ctrl)
	);

	// ============================================================
	// Video lane
	// ============================================================
	video_blanker #(
		.COLOR_BITS (COLOR_BITS)
	) i_video_blanker (
		.clk_24 (clk_24),
		.rst_n  (rst_n),
		.r      (r),
		.g      (g),
		.b      (b),
		.hs     (hs),
		.vs     (vs),
		.hb     (hb),
		.vb     (vb),
		.vga_r  (vga_r),
		.vga_g  (vga_g),
		.vga_b  (vga_b),
		.vga_hs (vga_hs),
		.vga_vs (vga_vs)
	);

	// ============================================================
	// Audio lane
	// ============================================================
	sound_mixer #(
		.AUDIO_BITS (AUDIO_BITS)
	) i_sound_mixer (
		.clk_24     (clk_24),
		.rst_n      (rst_n),
		.audio_a    (audio_a),
		.audio_b    (audio_b),
		.mix_sample (mix_sample)
	);

	sigma_delta_dac #(
		.AUDIO_BITS (AUDIO_BITS)
	) i_sigma_delta_dac (
		.clk_24     (clk_24),
		.rst_n      (rst_n),
		.mix_sample (mix_sample),
		.audio_l    (audio_l)
	);

	// Mono board, right pin mirrors left
	assign audio_r = audio_l;

endmodule

//--- sim/arcade_io_checker.sv
// Output checker for the arcade I/O testbench.
// Samples the DUT outputs on the falling clock edge and compares them with
// the expected values from the testbench reference model. Also counts
// audio pulses over one full modulator window on request, and keeps the
// running check and error counts for the final report.
module arcade_io_checker #(
	parameter int AUDIO_BITS = 11
) (
	input  logic       clk_24,
	// DUT outputs
	input  logic [6:0] p1_ctrl,
	input  logic [6:0] p2_ctrl,
	input  logic [5:0] vga_r,
	input  logic [5:0] vga_g,
	input  logic [5:0] vga_b,
	input  logic       vga_hs,
	input  logic       vga_vs,
	input  logic       audio_l,
	input  logic       audio_r,
	// Expected values from the reference model
	input  logic [6:0] exp_p1,
	input  logic [6:0] exp_p2,
	input  logic [5:0] exp_r,
	input  logic [5:0] exp_g,
	input  logic [5:0] exp_b,
	input  logic       exp_hs,
	input  logic       exp_vs,
	// Audio pin must stay low while set
	input  logic       quiet_check,
	// Pulse window request and its expected count
	input  logic       count_start,
	input  int         exp_ones,
	output logic       count_done,
	output int         check_count,
	output int         error_count
);

	// One full turn of the accumulator
	localparam int WINDOW = 1 << AUDIO_BITS;

	int ones;
	int seen;

	initial begin
		check_count = 0;
		error_count = 0;
		count_done  = 1'b0;
		ones        = 0;
		seen        = 0;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// ============================================================
	// Per-cycle compare, away from the active edge
	// ============================================================
	always @(negedge clk_24) begin
		compare_value("p1_ctrl", p1_ctrl, exp_p1);
		compare_value("p2_ctrl", p2_ctrl, exp_p2);
		compare_value("vga_r", vga_r, exp_r);
		compare_value("vga_g", vga_g, exp_g);
		compare_value("vga_b", vga_b, exp_b);
		compare_value("vga_hs", vga_hs, exp_hs);
		compare_value("vga_vs", vga_vs, exp_vs);
		// Mono board, both pins identical
		compare_value("audio_r", audio_r, audio_l);
		if (quiet_check) begin
			compare_value("audio_l", audio_l, 1'b0);
		end

		// Pulse window, restarts each time the request drops
		if (!count_start) begin
			ones       = 0;
			seen       = 0;
			count_done = 1'b0;
		end else if (!count_done) begin
			ones = ones + int'(audio_l);
			seen++;
			if (seen == WINDOW) begin
				compare_value("audio_l ones", ones, exp_ones);
				count_done = 1'b1;
			end
		end
	end

endmodule

//--- sim/tb_arcade_io.sv
// Testbench for the arcade cabinet I/O glue.
// Drives keyboard strobes, joysticks, video and sound from an LFSR, keeps
// a cycle-accurate reference model of every output lane and hands the
// expected values to the checker. Prints one line per test and a summary.
module tb_arcade_io
	import arcade_io_pkg::*;
();

	localparam int          CB         = 3;
	localparam int          AB         = 11;
	localparam logic [31:0] SEED       = 32'h8119_5def;
	localparam int          COUNT_WAIT = (1 << AB) + 64;

	logic          clk_24;
	logic          rst_n;
	logic          key_strobe;
	logic          key_pressed;
	logic [7:0]    key_code;
	logic [7:0]    joystick_0;
	logic [7:0]    joystick_1;
	logic          rotate;
	logic [CB-1:0] r;
	logic [CB-1:0] g;
	logic [CB-1:0] b;
	logic          hs;
	logic          vs;
	logic          hb;
	logic          vb;
	logic [7:0]    audio_a;
	logic [7:0]    audio_b;
	logic [6:0]    p1_ctrl;
	logic [6:0]    p2_ctrl;
	logic [5:0]    vga_r;
	logic [5:0]    vga_g;
	logic [5:0]    vga_b;
	logic          vga_hs;
	logic          vga_vs;
	logic          audio_l;
	logic          audio_r;

	// Reference model state and expected outputs
	logic [7:0]  key_model;
	logic [6:0]  exp_p1;
	logic [6:0]  exp_p2;
	logic [5:0]  exp_r;
	logic [5:0]  exp_g;
	logic [5:0]  exp_b;
	logic        exp_hs;
	logic        exp_vs;
	logic        quiet_check;
	logic        count_start;
	logic        count_done;
	int          exp_ones;
	int          check_count;
	int          error_count;
	int          last_checks;
	int          last_errors;
	logic        hung;
	logic [31:0] lfsr_state;

	always #50 clk_24 = ~clk_24;

	arcade_io #(
		.COLOR_BITS (CB),
		.AUDIO_BITS (AB)
	) i_dut (
		.clk_24 (clk_24), .rst_n (rst_n),
		.key_strobe (key_strobe), .key_pressed (key_pressed), .key_code (key_code),
		.joystick_0 (joystick_0), .joystick_1 (joystick_1), .rotate (rotate),
		.r (r), .g (g), .b (b), .hs (hs), .vs (vs), .hb (hb), .vb (vb),
		.audio_a (audio_a), .audio_b (audio_b),
		.p1_ctrl (p1_ctrl), .p2_ctrl (p2_ctrl),
		.vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
		.vga_hs (vga_hs), .vga_vs (vga_vs),
		.audio_l (audio_l), .audio_r (audio_r)
	);

	arcade_io_checker #(
		.AUDIO_BITS (AB)
	) i_checker (
		.clk_24 (clk_24),
		.p1_ctrl (p1_ctrl), .p2_ctrl (p2_ctrl),
		.vga_r (vga_r), .vga_g (vga_g), .vga_b (vga_b),
		.vga_hs (vga_hs), .vga_vs (vga_vs),
		.audio_l (audio_l), .audio_r (audio_r),
		.exp_p1 (exp_p1), .exp_p2 (exp_p2),
		.exp_r (exp_r), .exp_g (exp_g), .exp_b (exp_b),
		.exp_hs (exp_hs), .exp_vs (exp_vs),
		.quiet_check (quiet_check),
		.count_start (count_start), .exp_ones (exp_ones), .count_done (count_done),
		.check_count (check_count), .error_count (error_count)
	);

	// ============================================================
	// Random source and reference functions
	// ============================================================
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] known_code(input logic [2:0] idx);
		logic [7:0] table_sc [8];
		table_sc = '{SC_UP, SC_DOWN, SC_LEFT, SC_RIGHT,
			SC_COIN, SC_START1, SC_START2, SC_FIRE};
		return table_sc[idx];
	endfunction

	// Held key vector after one strobe
	function automatic logic [7:0] key_ref(input logic [7:0] keys, input logic [7:0] code,
		input logic pressed);
		logic [7:0] next;
		next = keys;
		for (int i = 0; i < 8; i++) begin
			if (known_code(3'(i)) == code) begin
				next[i] = pressed;
			end
		end
		return next;
	endfunction

	// Control word, bits coin start fire up down left right
	function automatic logic [6:0] ctrl_ref(input logic [7:0] keys, input logic [7:0] j0,
		input logic [7:0] j1, input logic rot, input logic second);
		logic [7:0] js;
		logic       up, down, left, right, fire, coin, start;
		js    = j0 | j1;
		up    = keys[KEY_UP] | js[JOY_UP];
		down  = keys[KEY_DOWN] | js[JOY_DOWN];
		left  = keys[KEY_LEFT] | js[JOY_LEFT];
		right = keys[KEY_RIGHT] | js[JOY_RIGHT];
		fire  = keys[KEY_FIRE] | js[JOY_FIRE];
		coin  = second ? 1'b0 : keys[KEY_COIN];
		start = second ? keys[KEY_START2] : keys[KEY_START1];
		if (rot) begin
			return {coin, start, fire, left, right, down, up};
		end else begin
			return {coin, start, fire, up, down, left, right};
		end
	endfunction

	// Top six bits of the colour repeated six times
	function automatic logic [5:0] color_ref(input logic [CB-1:0] c, input logic blank);
		logic [6*CB-1:0] rep;
		rep = {6{c}};
		return blank ? 6'd0 : rep[6*CB-1 -: 6];
	endfunction

	function automatic int mix_ref(input logic [7:0] a, input logic [7:0] bb);
		return int'(a) + 4 * int'(bb);
	endfunction

	// ============================================================
	// Reference model, same latency as each lane
	// ============================================================
	always @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			key_model <= '0;
			exp_p1    <= '0;
			exp_p2    <= '0;
			exp_r     <= '0;
			exp_g     <= '0;
			exp_b     <= '0;
			exp_hs    <= 1'b1;
			exp_vs    <= 1'b1;
		end else begin
			// Controls see the key state of the previous edge
			if (key_strobe) begin
				key_model <= key_ref(key_model, key_code, key_pressed);
			end
			exp_p1 <= ctrl_ref(key_model, joystick_0, joystick_1, rotate, 1'b0);
			exp_p2 <= ctrl_ref(key_model, joystick_0, joystick_1, rotate, 1'b1);
			exp_r  <= color_ref(r, hb | vb);
			exp_g  <= color_ref(g, hb | vb);
			exp_b  <= color_ref(b, hb | vb);
			exp_hs <= ~hs;
			exp_vs <= ~vs;
		end
	end

	// ============================================================
	// Stimulus tasks
	// ============================================================
	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(posedge clk_24);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= pressed;
		@(posedge clk_24);
		key_strobe  <= 1'b0;
		// Let the event reach both control words
		repeat (2) @(posedge clk_24);
	endtask

	// Mostly known codes, some random ones
	task automatic exercise_keys();
		logic [7:0] code;
		for (int i = 0; i < 48; i++) begin
			if (rand_bits(2) != 0) begin
				code = known_code(3'(rand_bits(3)));
			end else begin
				code = 8'(rand_bits(8));
			end
			send_key(code, rand_bits(1) == 1);
		end
	endtask

	task automatic merge_joysticks();
		// Random held key state first
		for (int k = 0; k < 8; k++) begin
			send_key(known_code(3'(k)), rand_bits(1) == 1);
		end
		for (int i = 0; i < 64; i++) begin
			@(posedge clk_24);
			joystick_0 <= 8'(rand_bits(8));
			joystick_1 <= 8'(rand_bits(8));
			rotate     <= rand_bits(1) == 1;
		end
		@(posedge clk_24);
		joystick_0 <= '0;
		joystick_1 <= '0;
		rotate     <= 1'b0;
	endtask

	task automatic sweep_video();
		for (int i = 0; i < 96; i++) begin
			@(posedge clk_24);
			r  <= CB'(rand_bits(CB));
			g  <= CB'(rand_bits(CB));
			b  <= CB'(rand_bits(CB));
			hs <= rand_bits(1) == 1;
			vs <= rand_bits(1) == 1;
			// Blank about one cycle in four per signal
			hb <= rand_bits(2) == 3;
			vb <= rand_bits(2) == 3;
		end
		@(posedge clk_24);
	endtask

	task automatic measure_audio();
		logic [7:0] a;
		logic [7:0] bb;
		int         waited;
		@(posedge clk_24);
		quiet_check <= 1'b0;
		for (int k = 0; k < 4 && !hung; k++) begin
			@(posedge clk_24);
			a  = 8'(rand_bits(8));
			bb = 8'(rand_bits(8));
			audio_a  <= a;
			audio_b  <= bb;
			exp_ones <= mix_ref(a, bb);
			// Mixer and modulator settle
			repeat (16) @(posedge clk_24);
			count_start <= 1'b1;
			waited = 0;
			@(posedge clk_24);
			while (!count_done && waited < COUNT_WAIT) begin
				@(posedge clk_24);
				waited++;
			end
			if (!count_done) begin
				$display("timeout: audio pulse window count never completed");
				hung = 1'b1;
			end
			count_start <= 1'b0;
			@(posedge clk_24);
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s done: %0d checks, %0d errors", name,
			check_count - last_checks, error_count - last_errors);
		last_checks = check_count;
		last_errors = error_count;
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		lfsr_state  = SEED;
		hung        = 1'b0;
		last_checks = 0;
		last_errors = 0;
		clk_24      = 1'b0;
		rst_n       = 1'b0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = '0;
		joystick_0  = '0;
		joystick_1  = '0;
		rotate      = 1'b0;
		{r, g, b}   = '0;
		{hs, vs}    = '0;
		{hb, vb}    = '0;
		audio_a     = '0;
		audio_b     = '0;
		quiet_check = 1'b1;
		count_start = 1'b0;
		exp_ones    = 0;

		repeat (8) @(posedge clk_24);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_24);
		report_test("reset");
		exercise_keys();
		report_test("key decode");
		merge_joysticks();
		report_test("joystick merge and rotation");
		sweep_video();
		report_test("video path");
		measure_audio();
		report_test("audio");

		$display("summary: %0d checks, %0d errors, timeout %0d", check_count, error_count,
			hung);
		if (error_count == 0 && !hung) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- arcade_io.f
hdl/arcade_io_pkg.sv
hdl/key_latch.sv
hdl/control_mapper.sv
hdl/sound_mixer.sv
hdl/sigma_delta_dac.sv
hdl/video_blanker.sv
hdl/arcade_io.sv
sim/arcade_io_checker.sv
sim/tb_arcade_io.sv

//--- Bender.yml
package:
  name: arcade_io

sources:
  # Design, in compile order
  - files:
      - hdl/arcade_io_pkg.sv
      - hdl/key_latch.sv
      - hdl/control_mapper.sv
      - hdl/sound_mixer.sv
      - hdl/sigma_delta_dac.sv
      - hdl/video_blanker.sv
      - hdl/arcade_io.sv

  # Testbench
  - target: simulation
    files:
      - sim/arcade_io_checker.sv
      - sim/tb_arcade_io.sv
